/* mem_pkg.sv */
// cache to axi memory path: bus widths, burst limit and channel payload structs
package mem_pkg;

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int strb_w    = data_w / 8;   // one bit per byte lane
    localparam int max_beats = 16;           // longest burst the cache issues

    typedef logic [7:0] len_t;               // beats minus one

    typedef struct packed {
        logic [addr_w-1:0] addr;             // word aligned
        len_t              len;
    } cache_rd_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        len_t              len;
    } cache_wr_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } wr_beat_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
    } rd_beat_t;

    // ar and aw share one layout
    typedef struct packed {
        logic [addr_w-1:0] addr;
        len_t              len;
    } axi_a_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

endpackage

/* axi_bridge.sv */
// data cache refill and write-back port to axi4, separate read and write FSMs
module axi_bridge (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  rd_req_valid,
    input  mem_pkg::cache_rd_req_t rd_req,
    output logic                  rd_beat_valid,
    output mem_pkg::rd_beat_t     rd_beat,
    input  logic                  wr_req_valid,
    input  mem_pkg::cache_wr_req_t wr_req,
    input  logic                  wr_beat_valid,
    input  mem_pkg::wr_beat_t     wr_beat,
    output logic                  wr_beat_ready,
    output logic                  wr_done_valid,
    input  logic                  wr_done_ready,
    output logic                  ar_valid,
    output mem_pkg::axi_a_t       ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  mem_pkg::axi_r_t       r,
    output logic                  r_ready,
    output logic                  aw_valid,
    output mem_pkg::axi_a_t       aw,
    input  logic                  aw_ready,
    output logic                  w_valid,
    output mem_pkg::axi_w_t       w,
    input  logic                  w_ready,
    input  logic                  b_valid,
    output logic                  b_ready
);
    typedef enum logic [1:0] {rd_idle, rd_addr, rd_beats} rd_state_t;
    typedef enum logic [1:0] {wr_idle, wr_addr, wr_beats, wr_resp} wr_state_t;

    rd_state_t rd_state, rd_next;
    wr_state_t wr_state, wr_next;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_state <= rd_idle;
            wr_state <= wr_idle;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    // request captured on leaving idle, the cache may drop it afterwards
    always_ff @(posedge clk) begin
        if (rd_state == rd_idle && rd_req_valid) begin
            ar.addr <= rd_req.addr;
            ar.len  <= rd_req.len;
        end
        if (wr_state == wr_idle && wr_req_valid) begin
            aw.addr <= wr_req.addr;
            aw.len  <= wr_req.len;
        end
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            rd_idle:  if (rd_req_valid) rd_next = rd_addr;
            rd_addr:  if (ar_ready) rd_next = rd_beats;
            rd_beats: if (r_valid && r.last) rd_next = rd_idle;
            default:  rd_next = rd_idle;
        endcase
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            wr_idle:  if (wr_req_valid) wr_next = wr_addr;
            wr_addr:  if (aw_ready) wr_next = wr_beats;
            wr_beats: if (w_valid && w_ready && w.last) wr_next = wr_resp;
            wr_resp:  if (b_valid && b_ready) wr_next = wr_idle;
            default:  wr_next = wr_idle;
        endcase
    end

    // read side, no stall toward the cache
    assign ar_valid      = (rd_state == rd_addr);
    assign r_ready       = (rd_state == rd_beats);
    assign rd_beat_valid = r_ready && r_valid;
    assign rd_beat.data  = r.data;
    assign rd_beat.last  = r.last;

    // write side, beats pass straight through in the data state
    assign aw_valid      = (wr_state == wr_addr);
    assign w_valid       = (wr_state == wr_beats) && wr_beat_valid;
    assign wr_beat_ready = (wr_state == wr_beats) && w_ready;
    assign w.data        = wr_beat.data;
    assign w.strb        = wr_beat.strb;
    assign w.last        = wr_beat.last;

    assign b_ready       = (wr_state == wr_resp) && wr_done_ready;
    assign wr_done_valid = (wr_state == wr_resp) && b_valid;   // held by the slave

endmodule

/* axi_mem.sv */
// axi4 slave word memory serving incrementing bursts with byte strobes
module axi_mem #(
    parameter int mem_words = 1024
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            ar_valid,
    input  mem_pkg::axi_a_t ar,
    output logic            ar_ready,
    output logic            r_valid,
    output mem_pkg::axi_r_t r,
    input  logic            r_ready,
    input  logic            aw_valid,
    input  mem_pkg::axi_a_t aw,
    output logic            aw_ready,
    input  logic            w_valid,
    input  mem_pkg::axi_w_t w,
    output logic            w_ready,
    output logic            b_valid,
    input  logic            b_ready
);
    import mem_pkg::*;

    localparam int         idx_w     = $clog2(mem_words);
    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [1:0] {wr_idle, wr_beats, wr_resp} wr_state_t;

    logic [data_w-1:0] mem [mem_words];

    logic              rd_busy;
    logic [idx_w-1:0]  rd_ptr;       // next word after the one on r
    len_t              rd_left;      // beats after the current one
    logic [data_w-1:0] rd_word;
    logic [idx_w-1:0]  ar_idx;
    logic              ar_fire;
    logic              r_fire;

    wr_state_t         wr_state;
    logic [idx_w-1:0]  wr_ptr;
    len_t              wr_left;
    logic [idx_w-1:0]  aw_idx;
    logic              w_fire;

    // byte offset dropped, upper bits wrap modulo depth
    assign ar_idx  = ar.addr[idx_w+1:2];
    assign aw_idx  = aw.addr[idx_w+1:2];

    assign ar_ready = !rd_busy;
    assign r_valid  = rd_busy;
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = r_valid && r_ready;

    assign r.data   = rd_word;
    assign r.resp   = resp_okay;
    assign r.last   = (rd_left == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_busy <= 1'b0;
            rd_ptr  <= '0;
            rd_left <= '0;
        end else if (ar_fire) begin
            rd_busy <= 1'b1;
            rd_ptr  <= ar_idx + 1'b1;
            rd_left <= ar.len;
        end else if (r_fire) begin
            if (rd_left == '0) begin
                rd_busy <= 1'b0;     // last beat taken
            end else begin
                rd_ptr  <= rd_ptr + 1'b1;
                rd_left <= rd_left - 1'b1;
            end
        end
    end

    // registered read data, first word lands one cycle after ar
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_word <= mem[ar_idx];
        end else if (r_fire && rd_left != '0) begin
            rd_word <= mem[rd_ptr];
        end
    end

    assign aw_ready = (wr_state == wr_idle);
    assign w_ready  = (wr_state == wr_beats);
    assign b_valid  = (wr_state == wr_resp);
    assign w_fire   = w_valid && w_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= wr_idle;
            wr_ptr   <= '0;
            wr_left  <= '0;
        end else begin
            case (wr_state)
                wr_idle: if (aw_valid) begin
                    wr_ptr   <= aw_idx;
                    wr_left  <= aw.len;
                    wr_state <= wr_beats;
                end
                wr_beats: if (w_fire) begin
                    if (wr_left == '0) begin
                        wr_state <= wr_resp;
                    end else begin
                        wr_ptr  <= wr_ptr + 1'b1;
                        wr_left <= wr_left - 1'b1;
                    end
                end
                wr_resp: if (b_ready) wr_state <= wr_idle;   // held until taken
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // byte merge under the strobe
    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int i = 0; i < strb_w; i++) begin
                if (w.strb[i]) begin
                    mem[wr_ptr][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

/* mem_subsys.sv */
// top level joining the cache-side axi bridge and the burst memory
module mem_subsys #(
    parameter int mem_words = 1024
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   rd_req_valid,
    input  mem_pkg::cache_rd_req_t rd_req,
    output logic                   rd_beat_valid,
    output mem_pkg::rd_beat_t      rd_beat,
    input  logic                   wr_req_valid,
    input  mem_pkg::cache_wr_req_t wr_req,
    input  logic                   wr_beat_valid,
    input  mem_pkg::wr_beat_t      wr_beat,
    output logic                   wr_beat_ready,
    output logic                   wr_done_valid,
    input  logic                   wr_done_ready
);
    import mem_pkg::*;

    // axi channels between bridge and memory
    logic   ar_valid, ar_ready;
    axi_a_t ar;
    logic   r_valid, r_ready;
    axi_r_t r;
    logic   aw_valid, aw_ready;
    axi_a_t aw;
    logic   w_valid, w_ready;
    axi_w_t w;
    logic   b_valid, b_ready;

    axi_bridge u_bridge (
        .clk           (clk),
        .rstn          (rstn),
        .rd_req_valid  (rd_req_valid),
        .rd_req        (rd_req),
        .rd_beat_valid (rd_beat_valid),
        .rd_beat       (rd_beat),
        .wr_req_valid  (wr_req_valid),
        .wr_req        (wr_req),
        .wr_beat_valid (wr_beat_valid),
        .wr_beat       (wr_beat),
        .wr_beat_ready (wr_beat_ready),
        .wr_done_valid (wr_done_valid),
        .wr_done_ready (wr_done_ready),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .r_ready       (r_ready),
        .aw_valid      (aw_valid),
        .aw            (aw),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w             (w),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_ready       (b_ready)
    );

    axi_mem #(
        .mem_words (mem_words)
    ) u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready),
        .aw_valid (aw_valid),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

/* mem_subsys_chk.sv */
// bound checker for the bridge's axi handshakes and burst order
module mem_subsys_chk (
    input logic            clk,
    input logic            rstn,
    input logic            ar_valid,
    input logic            ar_ready,
    input mem_pkg::axi_a_t ar,
    input logic            r_valid,
    input logic            r_ready,
    input mem_pkg::axi_r_t r,
    input logic            aw_valid,
    input logic            aw_ready,
    input mem_pkg::axi_a_t aw,
    input logic            w_valid,
    input logic            w_ready,
    input mem_pkg::axi_w_t w,
    input logic            b_valid,
    input logic            b_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic aw_open;   // aw taken, w beats may follow

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_open <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            aw_open <= 1'b1;
        end else if (w_valid && w_ready && w.last) begin
            aw_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar dropped or changed before its handshake");

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw dropped or changed before its handshake");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid)
        else $error("w_valid dropped before its handshake");

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before its handshake");

    // rready up for the whole read data phase
    r_ready_start: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && ar_ready |=> r_ready)
        else $error("r_ready low after the ar handshake");

    r_ready_burst: assert property (@(posedge clk) disable iff (!rstn)
        r_ready && !(r_valid && r.last) |=> r_ready)
        else $error("r_ready dropped inside a read burst");

    w_after_aw: assert property (@(posedge clk) disable iff (!rstn)
        w_valid |-> aw_open)
        else $error("w_valid raised before the aw handshake");

endmodule

bind axi_bridge mem_subsys_chk u_chk (.*);

/* tb_mem_subsys.sv */
// testbench for the cache memory subsystem, random bursts checked against a word model
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int mem_words  = 256;
    localparam int clk_period = 40;
    localparam int n_rand     = 30;
    localparam int n_strb     = 10;
    localparam int n_par      = 10;
    localparam int n_bp       = 8;
    localparam int n_bursts   = 2 + 2 * n_rand + 3 * n_strb + 3 * n_par + 2 * n_bp;

    logic          clk;
    logic          rstn;
    logic          rd_req_valid;
    cache_rd_req_t rd_req;
    logic          rd_beat_valid;
    rd_beat_t      rd_beat;
    logic          wr_req_valid;
    cache_wr_req_t wr_req;
    logic          wr_beat_valid;
    wr_beat_t      wr_beat;
    logic          wr_beat_ready;
    logic          wr_done_valid;
    logic          wr_done_ready;

    logic [data_w-1:0] model [mem_words];     // expected memory contents
    bit                written [mem_words];   // word fully written at least once
    int                seed = 58;

    mem_subsys #(
        .mem_words (mem_words)
    ) u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .rd_req_valid  (rd_req_valid),
        .rd_req        (rd_req),
        .rd_beat_valid (rd_beat_valid),
        .rd_beat       (rd_beat),
        .wr_req_valid  (wr_req_valid),
        .wr_req        (wr_req),
        .wr_beat_valid (wr_beat_valid),
        .wr_beat       (wr_beat),
        .wr_beat_ready (wr_beat_ready),
        .wr_done_valid (wr_done_valid),
        .wr_done_ready (wr_done_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // every burst gets 16 beats of 10 cycles at most
    initial begin
        #(n_bursts * 16 * 10 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped by the watchdog");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;   // drive point
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] aligned_addr();
        logic [31:0] a;
        a = random_word();
        return {a[31:2], 2'b00};
    endfunction

    // memory wraps modulo its depth
    function automatic int word_index(input logic [31:0] addr, input int beat);
        return int'(((addr >> 2) + 32'(beat)) % mem_words);
    endfunction

    task automatic merge_model(input int idx, input logic [31:0] data, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
        end
        if (strb == 4'hf) written[idx] = 1'b1;
    endtask

    // hold is the number of cycles wr_done_ready stays low
    task automatic write_burst(input logic [31:0] addr, input int beats, input bit strb_rand,
                               input int hold);
        logic [31:0] data;
        logic [3:0]  strb;
        bit          taken;
        wr_req_valid = 1'b1;
        wr_req.addr  = addr;
        wr_req.len   = len_t'(beats - 1);
        next_cycle();
        wr_req_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            data          = random_word();
            strb          = strb_rand ? 4'(pick_below(16)) : 4'hf;
            wr_beat_valid = 1'b1;
            wr_beat.data  = data;
            wr_beat.strb  = strb;
            wr_beat.last  = (i == beats - 1);
            taken         = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = wr_beat_ready;   // beat moves on the coming edge
                next_cycle();
            end
            merge_model(word_index(addr, i), data, strb);
        end
        wr_beat_valid = 1'b0;
        wr_beat       = '0;
        repeat (hold) begin
            @(negedge clk);
            check_value("write done held", 32'd1, 32'(wr_done_valid));
            next_cycle();
        end
        wr_done_ready = 1'b1;
        @(negedge clk);
        check_value("write done", 32'd1, 32'(wr_done_valid));
        next_cycle();
        wr_done_ready = 1'b0;
        @(negedge clk);
        check_value("write done cleared", 32'd0, 32'(wr_done_valid));
        next_cycle();
    endtask

    task automatic read_burst(input logic [31:0] addr, input int beats, input string name);
        int got;
        int idx;
        rd_req_valid = 1'b1;
        rd_req.addr  = addr;
        rd_req.len   = len_t'(beats - 1);
        next_cycle();
        rd_req_valid = 1'b0;
        got = 0;
        while (got < beats) begin
            @(negedge clk);
            if (rd_beat_valid) begin
                idx = word_index(addr, got);
                if (written[idx]) check_value(name, model[idx], rd_beat.data);
                check_value({name, " last"}, 32'(got == beats - 1), 32'(rd_beat.last));
                got++;
            end
            next_cycle();
        end
    endtask

    initial begin : main
        logic [31:0] addr;
        int          beats;
        int          beats_b;
        rstn          = 1'b0;
        rd_req_valid  = 1'b0;
        rd_req        = '0;
        wr_req_valid  = 1'b0;
        wr_req        = '0;
        wr_beat_valid = 1'b0;
        wr_beat       = '0;
        wr_done_ready = 1'b0;
        for (int i = 0; i < mem_words; i++) written[i] = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;

        @(negedge clk);
        check_value("reset rd_beat_valid", 32'd0, 32'(rd_beat_valid));
        check_value("reset wr_beat_ready", 32'd0, 32'(wr_beat_ready));
        check_value("reset wr_done_valid", 32'd0, 32'(wr_done_valid));
        next_cycle();

        addr = aligned_addr();
        write_burst(addr, 1, 1'b0, 0);
        read_burst(addr, 1, "single beat");

        for (int i = 0; i < n_rand; i++) begin
            addr  = aligned_addr();
            beats = 1 + pick_below(max_beats);
            write_burst(addr, beats, 1'b0, 0);
            read_burst(addr, beats, "burst readback");
        end

        // partial strobes over a fully written range
        for (int i = 0; i < n_strb; i++) begin
            addr  = aligned_addr();
            beats = 1 + pick_below(max_beats);
            write_burst(addr, beats, 1'b0, 0);
            write_burst(addr, beats, 1'b1, 0);
            read_burst(addr, beats, "strobe merge");
        end

        // second write lands half the memory away
        for (int i = 0; i < n_par; i++) begin
            addr    = aligned_addr();
            beats   = 1 + pick_below(max_beats);
            beats_b = 1 + pick_below(max_beats);
            write_burst(addr, beats, 1'b0, 0);
            fork
                read_burst(addr, beats, "parallel read");
                write_burst(addr + 32'(mem_words * 2), beats_b, 1'b1, 0);
            join
        end

        for (int i = 0; i < n_bp; i++) begin
            addr  = aligned_addr();
            beats = 1 + pick_below(max_beats);
            write_burst(addr, beats, 1'b0, 1 + pick_below(12));
            read_burst(addr, beats, "after back-pressure");
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog.f */
mem_pkg.sv
axi_bridge.sv
axi_mem.sv
mem_subsys.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_mem_subsys
FILELIST  := verilog.f
FLAGS     := --timing --assert --timescale 1ns/1ps
BUILD_DIR := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
